// ==== dcache_vectors.txt ====
# op addr wdata sel exp_data exp_reads, all hex except exp_reads (memory reads after the op)
# R read, W write (exp_data unused), I invalidate with the set number in addr
R 1234 00000000 f 5a5a048d 4
R 123c 00000000 f 5a5a048f 4
W 1238 a1b2c3d4 5 00000000 4
R 1238 00000000 f 5ab204d4 4
R 2050 00000000 f 5a5a0814 8
R 3054 00000000 f 5a5a0c15 12
R 2058 00000000 f 5a5a0816 12
R 405c 00000000 f 5a5a1017 16
R 2050 00000000 f 5a5a0814 16
R 3054 00000000 f 5a5a0c15 20
I 0003 00000000 0 00000000 20
R 1238 00000000 f 5ab204d4 24
R 2050 00000000 f 5a5a0814 24
W 7004 11223344 f 00000000 24
R 7004 00000000 f 11223344 28

// ==== compile.f ====
+incdir+.
dcache_pkg.sv
dcache_ifs.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_top.sv
tb_dcache_mem.sv
tb_dcache.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_dcache
FILELIST = compile.f
OBJ_DIR  = obj_dir
PASS_MSG = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_dcache.sv ====
////////////////////////////////////////
// Testbench for the two-way data cache
// Runs the operations of dcache_vectors.txt
// on the DUT with a Wishbone memory model,
// checks read data, memory read counts
// and the fixed read hit latency
////////////////////////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module tb_dcache;

   // Cycles allowed for any ack
   localparam int ACK_TIMEOUT = 100;

   logic                 clk;
   logic                 rst;
   logic                 cpu_cyc_i;
   logic                 cpu_stb_i;
   logic                 cpu_we_i;
   logic [`DC_SEL_W-1:0] cpu_sel_i;
   logic [`DC_ADR_W-1:0] cpu_adr_i;
   logic [`DC_DAT_W-1:0] cpu_dat_i;
   logic [`DC_DAT_W-1:0] cpu_dat_o;
   logic                 cpu_ack_o;
   logic                 mem_cyc_o;
   logic                 mem_stb_o;
   logic                 mem_we_o;
   logic [`DC_SEL_W-1:0] mem_sel_o;
   logic [`DC_ADR_W-1:0] mem_adr_o;
   logic [`DC_DAT_W-1:0] mem_dat_o;
   logic [`DC_DAT_W-1:0] mem_dat_i;
   logic                 mem_ack_i;
   logic                 inv_req_i;
   logic [`DC_IDX_W-1:0] inv_set_i;
   logic                 inv_ack_o;
   // Read beats served by the memory model
   logic [31:0]          mem_reads;

   // Fields of the current vector
   logic [7:0]           op;
   logic [`DC_ADR_W-1:0] v_adr;
   logic [`DC_DAT_W-1:0] v_dat;
   logic [`DC_SEL_W-1:0] v_sel;
   logic [`DC_DAT_W-1:0] exp_dat;
   int                   exp_reads;
   int                   prev_reads;
   int                   errors;
   int                   timeouts;
   int                   vec_count;
   int                   fd;
   logic [8*160-1:0]     line_buf;

   dcache_top u_dcache_top (.*);

   tb_dcache_mem u_mem (
      .clk(clk), .rst(rst),
      .cyc_i(mem_cyc_o), .stb_i(mem_stb_o), .we_i(mem_we_o),
      .sel_i(mem_sel_o), .adr_i(mem_adr_o), .dat_i(mem_dat_o),
      .dat_o(mem_dat_i), .ack_o(mem_ack_i), .read_count_o(mem_reads)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // One classic transfer, cycles counted from the DUT sampling edge to ack
   task automatic cpu_transfer(input logic we, input logic [`DC_SEL_W-1:0] sel,
                               output logic [`DC_DAT_W-1:0] rdat, output int cycles,
                               output bit ok);
      int waited;
      waited = 0;
      ok = 1'b0;
      @(posedge clk);
      cpu_cyc_i <= 1'b1;
      cpu_stb_i <= 1'b1;
      cpu_we_i  <= we;
      cpu_sel_i <= sel;
      cpu_adr_i <= v_adr;
      cpu_dat_i <= v_dat;
      // Ack looked at mid-cycle
      while (!ok && waited < ACK_TIMEOUT) begin
         @(negedge clk);
         waited++;
         ok = cpu_ack_o;
      end
      rdat = cpu_dat_o;
      // First negedge comes before the DUT samples stb
      cycles = waited - 1;
      if (!ok) begin
         $display("Timeout: no CPU ack for address 0x%h", v_adr);
      end
      @(posedge clk);
      cpu_cyc_i <= 1'b0;
      cpu_stb_i <= 1'b0;
      cpu_we_i  <= 1'b0;
   endtask

   // Request held until the one-cycle ack
   task automatic invalidate_set(output bit ok);
      int waited;
      waited = 0;
      ok = 1'b0;
      @(posedge clk);
      inv_req_i <= 1'b1;
      inv_set_i <= v_adr[`DC_IDX_W-1:0];
      while (!ok && waited < ACK_TIMEOUT) begin
         @(negedge clk);
         waited++;
         ok = inv_ack_o;
      end
      if (!ok) begin
         $display("Timeout: no invalidate ack for set %0d", v_adr[`DC_IDX_W-1:0]);
      end
      @(posedge clk);
      inv_req_i <= 1'b0;
   endtask

   task automatic run_vector();
      logic [`DC_DAT_W-1:0] rdat;
      int                   cycles;
      bit                   ok;
      ok = 1'b1;
      vec_count++;
      case (op)
         "R": begin
            cpu_transfer(1'b0, '1, rdat, cycles, ok);
            if (ok && rdat !== exp_dat) begin
               $display("Error at %0t: read of 0x%h gave 0x%h, expected 0x%h",
                        $time, v_adr, rdat, exp_dat);
               errors++;
            end
            // No new memory reads, so a hit with its fixed latency
            if (ok && exp_reads == prev_reads && cycles != 2) begin
               $display("Error at %0t: hit at 0x%h acked after %0d cycles, expected 2",
                        $time, v_adr, cycles);
               errors++;
            end
         end
         "W": cpu_transfer(1'b1, v_sel, rdat, cycles, ok);
         "I": invalidate_set(ok);
         default: begin
            $display("Unknown operation in vector %0d", vec_count);
            errors++;
         end
      endcase
      if (!ok) begin
         timeouts++;
      end else if (mem_reads != exp_reads) begin
         $display("Error at %0t: %0d memory reads after vector %0d, expected %0d",
                  $time, mem_reads, vec_count, exp_reads);
         errors++;
      end
      prev_reads = exp_reads;
   endtask

   initial begin
      rst        = 1'b1;
      cpu_cyc_i  = 1'b0;
      cpu_stb_i  = 1'b0;
      cpu_we_i   = 1'b0;
      cpu_sel_i  = '0;
      cpu_adr_i  = '0;
      cpu_dat_i  = '0;
      inv_req_i  = 1'b0;
      inv_set_i  = '0;
      errors     = 0;
      timeouts   = 0;
      vec_count  = 0;
      prev_reads = 0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      fd = $fopen("dcache_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open dcache_vectors.txt");
         errors++;
      end else begin
         // Column lines start with #, the run stops at the first timeout
         while (timeouts == 0 && $fgets(line_buf, fd) != 0) begin
            if ($sscanf(line_buf, "%s %h %h %h %h %d", op, v_adr, v_dat, v_sel,
                        exp_dat, exp_reads) == 6 && op != "#") begin
               run_vector();
            end
         end
         $fclose(fd);
      end
      $display("Vectors run: %0d, errors: %0d, timeouts: %0d", vec_count, errors, timeouts);
      if (errors == 0 && timeouts == 0 && vec_count > 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// ==== tb_dcache_mem.sv ====
////////////////////////////////////////
// Wishbone classic memory for the cache
// testbench. Word A starts as A ^ 5a5a0000,
// writes merge by byte select and every
// read beat is counted
////////////////////////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module tb_dcache_mem (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cyc_i,
   input  logic                 stb_i,
   input  logic                 we_i,
   input  logic [`DC_SEL_W-1:0] sel_i,
   input  logic [`DC_ADR_W-1:0] adr_i,
   input  logic [`DC_DAT_W-1:0] dat_i,
   output logic [`DC_DAT_W-1:0] dat_o,
   output logic                 ack_o,
   output logic [31:0]          read_count_o
);

   localparam int WORDS = 1 << (`DC_ADR_W - 2);

   logic [`DC_DAT_W-1:0] mem_q [WORDS];
   logic [`DC_ADR_W-3:0] wadr;

   // Word address, byte bits dropped
   assign wadr = adr_i[`DC_ADR_W-1:2];

   // Contents follow the full word address
   initial begin
      for (int a = 0; a < WORDS; a++) begin
         mem_q[a] = a ^ 32'h5a5a_0000;
      end
   end

   // Registered ack, low for a cycle after each beat so a held stb is served again
   always @(posedge clk) begin
      if (rst) begin
         ack_o        <= 1'b0;
         read_count_o <= '0;
      end else if (cyc_i && stb_i && !ack_o) begin
         ack_o <= 1'b1;
         if (we_i) begin
            for (int b = 0; b < `DC_SEL_W; b++) begin
               if (sel_i[b]) begin
                  mem_q[wadr][8*b +: 8] <= dat_i[8*b +: 8];
               end
            end
         end else begin
            dat_o        <= mem_q[wadr];
            read_count_o <= read_count_o + 1;
         end
      end else begin
         ack_o <= 1'b0;
      end
   end

endmodule

// ==== dcache_top.sv ====
////////////////////////////////////////
// Two-way write-through data cache
// CPU side is a Wishbone classic slave,
// memory side a Wishbone classic master,
// plus a set invalidate request
////////////////////////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_top (
   input  logic                 clk,
   input  logic                 rst,
   // CPU slave
   input  logic                 cpu_cyc_i,
   input  logic                 cpu_stb_i,
   input  logic                 cpu_we_i,
   input  logic [`DC_SEL_W-1:0] cpu_sel_i,
   input  logic [`DC_ADR_W-1:0] cpu_adr_i,
   input  logic [`DC_DAT_W-1:0] cpu_dat_i,
   output logic [`DC_DAT_W-1:0] cpu_dat_o,
   output logic                 cpu_ack_o,
   // Memory master
   output logic                 mem_cyc_o,
   output logic                 mem_stb_o,
   output logic                 mem_we_o,
   output logic [`DC_SEL_W-1:0] mem_sel_o,
   output logic [`DC_ADR_W-1:0] mem_adr_o,
   output logic [`DC_DAT_W-1:0] mem_dat_o,
   input  logic [`DC_DAT_W-1:0] mem_dat_i,
   input  logic                 mem_ack_i,
   // Invalidate
   input  logic                 inv_req_i,
   input  logic [`DC_IDX_W-1:0] inv_set_i,
   output logic                 inv_ack_o
);

   dcache_tag_if  tag_if ();
   dcache_data_if data_if ();

   dcache_tag_store u_tag_store (.clk(clk), .rst(rst), .tag(tag_if.store));

   dcache_data_store u_data_store (.clk(clk), .data(data_if.store));

   dcache_ctrl u_ctrl (
      .clk(clk), .rst(rst),
      .cpu_cyc_i(cpu_cyc_i), .cpu_stb_i(cpu_stb_i), .cpu_we_i(cpu_we_i),
      .cpu_sel_i(cpu_sel_i), .cpu_adr_i(cpu_adr_i), .cpu_dat_i(cpu_dat_i),
      .cpu_dat_o(cpu_dat_o), .cpu_ack_o(cpu_ack_o),
      .mem_cyc_o(mem_cyc_o), .mem_stb_o(mem_stb_o), .mem_we_o(mem_we_o),
      .mem_sel_o(mem_sel_o), .mem_adr_o(mem_adr_o), .mem_dat_o(mem_dat_o),
      .mem_dat_i(mem_dat_i), .mem_ack_i(mem_ack_i),
      .inv_req_i(inv_req_i), .inv_set_i(inv_set_i), .inv_ack_o(inv_ack_o),
      .tag(tag_if.ctrl), .data(data_if.ctrl)
   );

endmodule

// ==== dcache_ctrl.sv ====
////////////////////////////////////////
// Cache controller FSM
// Wishbone classic slave to the CPU and
// master to memory, lookup and respond
// stages, refill, write-through and
// set invalidate
////////////////////////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_ctrl (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cpu_cyc_i,
   input  logic                 cpu_stb_i,
   input  logic                 cpu_we_i,
   input  logic [`DC_SEL_W-1:0] cpu_sel_i,
   input  logic [`DC_ADR_W-1:0] cpu_adr_i,
   input  logic [`DC_DAT_W-1:0] cpu_dat_i,
   output logic [`DC_DAT_W-1:0] cpu_dat_o,
   output logic                 cpu_ack_o,
   output logic                 mem_cyc_o,
   output logic                 mem_stb_o,
   output logic                 mem_we_o,
   output logic [`DC_SEL_W-1:0] mem_sel_o,
   output logic [`DC_ADR_W-1:0] mem_adr_o,
   output logic [`DC_DAT_W-1:0] mem_dat_o,
   input  logic [`DC_DAT_W-1:0] mem_dat_i,
   input  logic                 mem_ack_i,
   input  logic                 inv_req_i,
   input  logic [`DC_IDX_W-1:0] inv_set_i,
   output logic                 inv_ack_o,
   dcache_tag_if.ctrl           tag,
   dcache_data_if.ctrl          data
);

   dcache_pkg::dc_state_e state_q;
   dcache_pkg::dc_addr_t  cpu_a;
   logic                  hit_q;      // Lookup hit, asks for an LRU update
   logic                  done_q;     // Transfer may be acked in RESPOND
   logic                  way_q;      // Hit way, or victim on a miss
   logic [`DC_WRD_W-1:0]  ref_cnt_q;
   logic [`DC_DAT_W-1:0]  rdata_q;
   logic [`DC_IDX_W-1:0]  inv_set_q;
   logic                  refill, wthru, ref_last;

   assign cpu_a    = dcache_pkg::dc_addr_t'(cpu_adr_i);
   assign refill   = (state_q == dcache_pkg::REFILL);
   assign wthru    = (state_q == dcache_pkg::WRITE_THRU);
   assign ref_last = (int'(ref_cnt_q) == `DC_WORDS - 1);

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q   <= dcache_pkg::IDLE;
         hit_q     <= 1'b0;
         done_q    <= 1'b0;
         way_q     <= 1'b0;
         ref_cnt_q <= '0;
      end else begin
         case (state_q)
            // Invalidate wins over a new CPU transfer
            dcache_pkg::IDLE: begin
               if (inv_req_i) state_q <= dcache_pkg::INVALIDATE;
               else if (cpu_cyc_i && cpu_stb_i) state_q <= dcache_pkg::LOOKUP;
            end
            // Stores were read on the sampling edge, compare now
            dcache_pkg::LOOKUP: begin
               hit_q  <= |tag.hit;
               way_q  <= (|tag.hit) ? tag.hit[1] : tag.victim;
               // A write always completes, read misses refill first
               done_q  <= cpu_we_i || (|tag.hit);
               state_q <= cpu_we_i ? dcache_pkg::WRITE_THRU : dcache_pkg::RESPOND;
            end
            dcache_pkg::RESPOND: begin
               ref_cnt_q <= '0;
               state_q   <= done_q ? dcache_pkg::IDLE : dcache_pkg::REFILL;
            end
            dcache_pkg::REFILL: begin
               if (mem_ack_i) begin
                  ref_cnt_q <= ref_cnt_q + 1'b1;
                  // Tag entry is written on this edge, no LRU pass in RESPOND
                  if (ref_last) begin
                     hit_q   <= 1'b0;
                     done_q  <= 1'b1;
                     state_q <= dcache_pkg::RESPOND;
                  end
               end
            end
            dcache_pkg::WRITE_THRU: begin
               if (mem_ack_i) state_q <= dcache_pkg::RESPOND;
            end
            default: state_q <= dcache_pkg::IDLE;
         endcase
      end
   end

   // Read data, from the hitting way or forwarded from the refill
   always_ff @(posedge clk) begin
      if (state_q == dcache_pkg::LOOKUP) rdata_q <= data.rdata[tag.hit[1]];
      if (refill && mem_ack_i && ref_cnt_q == cpu_a.word) rdata_q <= mem_dat_i;
      if (state_q == dcache_pkg::IDLE) inv_set_q <= inv_set_i;
   end

   assign cpu_dat_o = rdata_q;
   assign cpu_ack_o = (state_q == dcache_pkg::RESPOND) && done_q;
   assign inv_ack_o = (state_q == dcache_pkg::INVALIDATE);

   // Tag side, the invalidate set replaces the CPU index
   assign tag.idx      = inv_ack_o ? inv_set_q : cpu_a.idx;
   assign tag.cmp_tag  = cpu_a.tag;
   assign tag.fill_tag = cpu_a.tag;
   assign tag.wr_way   = way_q;
   assign tag.clr      = inv_ack_o;
   assign tag.we       = ((state_q == dcache_pkg::RESPOND) && hit_q) ||
                         (refill && mem_ack_i && ref_last);

   // Data side, refill words land in the victim, write hits merge bytes
   assign data.addr  = {cpu_a.idx, refill ? ref_cnt_q : cpu_a.word};
   assign data.be    = refill ? '1 : cpu_sel_i;
   assign data.wdata = refill ? mem_dat_i : cpu_dat_i;
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         data.we[w] = (way_q == w[0]) && mem_ack_i && (refill || (wthru && hit_q));
      end
   end

   // Memory master, held by state and counter until acked
   assign mem_cyc_o = refill || wthru;
   assign mem_stb_o = refill || wthru;
   assign mem_we_o  = wthru;
   assign mem_sel_o = wthru ? cpu_sel_i : '1;
   assign mem_adr_o = refill ? {cpu_a.tag, cpu_a.idx, ref_cnt_q, 2'b00}
                             : {cpu_adr_i[`DC_ADR_W-1:2], 2'b00};
   assign mem_dat_o = cpu_dat_i;

   a_ack_in_stb : assert property (@(posedge clk) disable iff (rst)
      cpu_ack_o |-> cpu_stb_i);
   // Whole memory request stays put until the slave acks
   a_stb_held : assert property (@(posedge clk) disable iff (rst)
      mem_stb_o && !mem_ack_i |=> mem_stb_o && $stable(mem_we_o) && $stable(mem_adr_o)
         && $stable(mem_sel_o) && $stable(mem_dat_o));

endmodule

// ==== dcache_data_store.sv ====
////////////////////////////////////////
// Data arrays of both ways, 64 words each
// Synchronous read of both ways at once,
// byte-enabled write to one way
////////////////////////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_data_store (
   input logic          clk,
   dcache_data_if.store data
);

   localparam int unsigned DEPTH = `DC_SETS * `DC_WORDS;

   logic [`DC_DAT_W-1:0] mem_q [`DC_WAYS][DEPTH];
   logic [`DC_WAYS-1:0][`DC_DAT_W-1:0] rd_q;

   always_ff @(posedge clk) begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         // Merge only the selected bytes
         for (int b = 0; b < `DC_SEL_W; b++) begin
            if (data.we[w] && data.be[b]) begin
               mem_q[w][data.addr][8*b +: 8] <= data.wdata[8*b +: 8];
            end
         end
         // Old contents on a same-cycle write
         rd_q[w] <= mem_q[w][data.addr];
      end
   end

   assign data.rdata = rd_q;

endmodule

// ==== dcache_tag_store.sv ====
////////////////////////////////////////
// Tag, valid and LRU storage for 16 sets
// Reads the addressed set every cycle,
// compares both ways against the CPU tag
// and names the LRU way as victim
////////////////////////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_tag_store (
   input logic         clk,
   input logic         rst,
   dcache_tag_if.store tag
);

   // Valid bits per set, one per way
   logic [`DC_WAYS-1:0] valid_q [`DC_SETS];
   // One LRU bit per set, names the way to replace next
   logic [`DC_SETS-1:0] lru_q;
   logic [`DC_TAG_W-1:0] tag_mem [`DC_WAYS][`DC_SETS];

   // Registered read of the set
   dcache_pkg::dc_tag_entry_t rd_ent [`DC_WAYS];
   logic                      rd_lru;

   // Control state, cleared on reset
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < `DC_SETS; s++) begin
            valid_q[s] <= '0;
         end
         lru_q <= '0;
      end else if (tag.clr) begin
         valid_q[tag.idx] <= '0;
      end else if (tag.we) begin
         valid_q[tag.idx][tag.wr_way] <= 1'b1;
         // Point away from the way just used
         lru_q[tag.idx] <= ~tag.wr_way;
      end
   end

   // Tag array and read port
   always_ff @(posedge clk) begin
      if (tag.we) begin
         tag_mem[tag.wr_way][tag.idx] <= tag.fill_tag;
      end
      for (int w = 0; w < `DC_WAYS; w++) begin
         rd_ent[w].valid <= valid_q[tag.idx][w];
         rd_ent[w].tag   <= tag_mem[w][tag.idx];
      end
      rd_lru <= lru_q[tag.idx];
   end

   // Compare stage, uses the entries read on the last edge
   always_comb begin
      for (int w = 0; w < `DC_WAYS; w++) begin
         tag.hit[w] = rd_ent[w].valid && (rd_ent[w].tag == tag.cmp_tag);
      end
   end

   assign tag.victim = rd_lru;

   // Refill only on a miss and no allocate on write, so a tag lives in one way only
   a_hit_one_way : assert property (@(posedge clk) disable iff (rst)
      !(&tag.hit));

endmodule

// ==== dcache_ifs.sv ====
////////////////////////////////////////
// Internal links of the data cache
// Tag link between controller and tag store,
// data link between controller and way arrays
////////////////////////////////////////

`timescale 1ns/1ps

`include "dcache_consts.svh"

interface dcache_tag_if;
   // Set read every cycle, also the write and clear target
   logic [`DC_IDX_W-1:0] idx;
   logic [`DC_TAG_W-1:0] cmp_tag;
   // Fill or LRU update of one way
   logic                 we;
   logic                 wr_way;
   logic [`DC_TAG_W-1:0] fill_tag;
   // Drop both valid bits of the set
   logic                 clr;
   // Results of the registered read
   logic [`DC_WAYS-1:0]  hit;
   logic                 victim;

   modport ctrl (output idx, cmp_tag, we, wr_way, fill_tag, clr, input hit, victim);
   modport store (input idx, cmp_tag, we, wr_way, fill_tag, clr, output hit, victim);
endinterface

interface dcache_data_if;
   // Same word address for the read of both ways and the write
   logic [`DC_LINE_W-1:0]               addr;
   logic [`DC_WAYS-1:0]                 we;
   logic [`DC_SEL_W-1:0]                be;
   logic [`DC_DAT_W-1:0]                wdata;
   // Both ways, one cycle after the address
   logic [`DC_WAYS-1:0][`DC_DAT_W-1:0]  rdata;

   modport ctrl (output addr, we, be, wdata, input rdata);
   modport store (input addr, we, be, wdata, output rdata);
endinterface

// ==== dcache_pkg.sv ====
////////////////////////////////////////
// Shared types of the data cache
// Controller states, stored tag entry and
// the split of a CPU byte address
////////////////////////////////////////

`include "dcache_consts.svh"

package dcache_pkg;

   // Controller states
   // LOOKUP and RESPOND are the two pipeline stages of a transfer
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      RESPOND,
      REFILL,
      WRITE_THRU,
      INVALIDATE
   } dc_state_e;

   // One way's entry in a set
   typedef struct packed {
      logic                 valid;
      logic [`DC_TAG_W-1:0] tag;
   } dc_tag_entry_t;

   // CPU byte address, MSB first
   typedef struct packed {
      logic [`DC_TAG_W-1:0]            tag;
      logic [`DC_IDX_W-1:0]            idx;
      // Word within the block
      logic [`DC_WRD_W-1:0]            word;
      // Byte within the word, covered by the selects
      logic [`DC_OFS_W-`DC_WRD_W-1:0]  byte_ofs;
   } dc_addr_t;

endpackage

// ==== dcache_consts.svh ====
////////////////////////////////////////
// Fixed geometry of the two-way data cache
// Include in any file that sizes a port,
// an array or a field of the cache
////////////////////////////////////////

`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// Byte address and data widths
`define DC_ADR_W 16
`define DC_DAT_W 32
`define DC_SEL_W 4

// 16-byte blocks, four words each
`define DC_OFS_W 4
`define DC_WORDS 4
`define DC_WRD_W ($clog2(`DC_WORDS))

// 16 sets
`define DC_IDX_W 4
`define DC_SETS (1 << `DC_IDX_W)

// Tag is what is left above index and offset
`define DC_TAG_W (`DC_ADR_W - `DC_OFS_W - `DC_IDX_W)

// Set index plus word in block, addresses one data word of a way
`define DC_LINE_W (`DC_IDX_W + `DC_WRD_W)

`define DC_WAYS 2

`endif
